/* include/matmul_settings.svh */
`ifndef MATMUL_SETTINGS_SVH
`define MATMUL_SETTINGS_SVH

// array side, also the max of N, K and M
`define MATMUL_DIM 4

`define MATMUL_DATA_W 8 // signed operand width
`define MATMUL_ACC_W 16 // accumulator width per pe
`define MATMUL_BUS_W 32 // register and result word width
`define MATMUL_ADDR_W 4 // register address width

// start to done, fixed for every dimension
`define MATMUL_LATENCY (3 * `MATMUL_DIM)

`define MATMUL_CTRL_ADDR 8 // control word address

`endif

/* rtl/matmul_pkg.sv */
`include "matmul_settings.svh"

package matmul_pkg;

  typedef logic signed [`MATMUL_DATA_W-1:0] elem_t; // one operand
  typedef logic signed [`MATMUL_ACC_W-1:0] acc_t; // one accumulator
  typedef logic [`MATMUL_BUS_W-1:0] word_t; // register or result word
  typedef logic [$clog2(`MATMUL_DIM)-1:0] dim_t; // size minus one
  typedef logic [`MATMUL_ADDR_W-1:0] reg_addr_t; // register address
  typedef logic [`MATMUL_DIM*`MATMUL_DIM-1:0] flags_t; // overflow per element

  // job handed from register block to array
  typedef struct packed {
    word_t [`MATMUL_DIM-1:0] a_rows; // word r = row r, byte k = element k
    word_t [`MATMUL_DIM-1:0] b_cols; // word c = column c, byte k = element k
    dim_t dim_n; // rows of A minus one
    dim_t dim_k; // inner size minus one
    dim_t dim_m; // columns of B minus one
  } matmul_job_t;

  // packed row-major with stride M
  typedef struct packed {
    word_t [`MATMUL_DIM*`MATMUL_DIM-1:0] data; // sign-extended elements
    flags_t flags; // sticky overflow, same index as data
  } matmul_result_t;

  // array run control
  typedef enum logic [1:0] {
    ARRAY_IDLE,
    ARRAY_RUN,
    ARRAY_DONE
  } array_state_e;

endpackage

/* rtl/matmul_pe.sv */
`timescale 1ns/100ps
`include "matmul_settings.svh"

module matmul_pe (
  input  logic clk_i,
  input  logic reset_i,
  input  logic clear_i, // new job, zero acc and flag
  input  matmul_pkg::elem_t a_i, // from left neighbor
  input  matmul_pkg::elem_t b_i, // from upper neighbor
  output matmul_pkg::elem_t a_o, // to right neighbor
  output matmul_pkg::elem_t b_o, // to lower neighbor
  output matmul_pkg::acc_t acc_o,
  output logic ovf_o
);

  matmul_pkg::acc_t prod; // 8x8 signed fits in 16 bits
  matmul_pkg::acc_t sum; // wraps on overflow
  logic wrap; // signed add left the range

  assign prod = a_i * b_i;
  assign sum = acc_o + prod;
  // same-sign operands, result sign flipped
  assign wrap = (acc_o[`MATMUL_ACC_W-1] == prod[`MATMUL_ACC_W-1]) &&
                (sum[`MATMUL_ACC_W-1] != acc_o[`MATMUL_ACC_W-1]);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      a_o <= '0;
      b_o <= '0;
      acc_o <= '0;
      ovf_o <= 1'b0;
    end
    else
    begin
      a_o <= a_i; // one cycle pass-through
      b_o <= b_i;
      if (clear_i)
      begin
        acc_o <= '0;
        ovf_o <= 1'b0;
      end
      else
      begin
        acc_o <= sum; // mac
        ovf_o <= ovf_o | wrap; // sticky
      end
    end
  end

endmodule

/* rtl/matmul_array.sv */
`timescale 1ns/100ps
`include "matmul_settings.svh"

module matmul_array (
  input  logic clk_i,
  input  logic reset_i,
  input  logic start_i, // one-cycle strobe from register block
  input  matmul_pkg::matmul_job_t job_i, // sampled with start
  output logic busy_o,
  output logic done_o, // one-cycle, result valid with it
  output matmul_pkg::matmul_result_t result_o
);

  // last mac lands at step 3*(DIM-1), results read one step later
  localparam int LAST_STEP = `MATMUL_LATENCY - 2;
  localparam int STEP_W = $clog2(`MATMUL_LATENCY);

  matmul_pkg::array_state_e state_q;
  logic [STEP_W-1:0] step_q; // feed step within the run
  matmul_pkg::matmul_job_t job_q; // captured operands
  matmul_pkg::matmul_result_t result_next; // packed view of the grid
  logic pe_clear;

  // grid wiring, a flows right and b flows down
  matmul_pkg::elem_t a_grid [`MATMUL_DIM][`MATMUL_DIM+1];
  matmul_pkg::elem_t b_grid [`MATMUL_DIM+1][`MATMUL_DIM];
  matmul_pkg::acc_t acc_grid [`MATMUL_DIM][`MATMUL_DIM];
  logic ovf_grid [`MATMUL_DIM][`MATMUL_DIM];
  matmul_pkg::elem_t a_feed [`MATMUL_DIM]; // left edge, one per row
  matmul_pkg::elem_t b_feed [`MATMUL_DIM]; // top edge, one per column

  assign busy_o = (state_q != matmul_pkg::ARRAY_IDLE);
  assign pe_clear = start_i && (state_q == matmul_pkg::ARRAY_IDLE); // fresh job only

  // skewed edge feed, row r gets element k at step r+k
  always_comb
  begin
    int k;
    for (int r = 0; r < `MATMUL_DIM; r++)
    begin
      a_feed[r] = '0; // zeros outside the window
      b_feed[r] = '0;
      k = int'(step_q) - r;
      if ((state_q == matmul_pkg::ARRAY_RUN) && (k >= 0) && (k <= int'(job_q.dim_k)))
      begin
        a_feed[r] = job_q.a_rows[r][k*`MATMUL_DATA_W +: `MATMUL_DATA_W]; // A row r
        b_feed[r] = job_q.b_cols[r][k*`MATMUL_DATA_W +: `MATMUL_DATA_W]; // B col r
      end
    end
  end

  for (genvar r = 0; r < `MATMUL_DIM; r++)
  begin : g_row
    assign a_grid[r][0] = a_feed[r];
    assign b_grid[0][r] = b_feed[r]; // r picks the column here
    for (genvar c = 0; c < `MATMUL_DIM; c++)
    begin : g_col
      matmul_pe i_matmul_pe (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .clear_i (pe_clear),
        .a_i     (a_grid[r][c]),
        .b_i     (b_grid[r][c]),
        .a_o     (a_grid[r][c+1]),
        .b_o     (b_grid[r+1][c]),
        .acc_o   (acc_grid[r][c]),
        .ovf_o   (ovf_grid[r][c])
      );
    end
  end

  // row-major pack with stride M, rest stays zero
  always_comb
  begin
    int idx;
    result_next = '0;
    for (int r = 0; r < `MATMUL_DIM; r++)
    begin
      for (int c = 0; c < `MATMUL_DIM; c++)
      begin
        idx = r * (int'(job_q.dim_m) + 1) + c;
        if ((r <= int'(job_q.dim_n)) && (c <= int'(job_q.dim_m)))
        begin
          result_next.data[idx] = {{(`MATMUL_BUS_W-`MATMUL_ACC_W){acc_grid[r][c][`MATMUL_ACC_W-1]}},
                                   acc_grid[r][c]}; // sign extend
          result_next.flags[idx] = ovf_grid[r][c];
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (start_i && (state_q == matmul_pkg::ARRAY_IDLE))
      job_q <= job_i; // held for the whole run
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_q <= matmul_pkg::ARRAY_IDLE;
      step_q <= '0;
      done_o <= 1'b0;
      result_o <= '0;
    end
    else
    begin
      done_o <= 1'b0;
      case (state_q)
        matmul_pkg::ARRAY_IDLE:
        begin
          step_q <= '0;
          if (start_i)
            state_q <= matmul_pkg::ARRAY_RUN;
        end
        matmul_pkg::ARRAY_RUN:
        begin
          if (step_q == STEP_W'(LAST_STEP))
          begin
            state_q <= matmul_pkg::ARRAY_DONE;
            done_o <= 1'b1;
            result_o <= result_next; // holds until next done
          end
          else
            step_q <= step_q + 1'b1;
        end
        matmul_pkg::ARRAY_DONE:
          state_q <= matmul_pkg::ARRAY_IDLE; // busy drops after done
        default:
          state_q <= matmul_pkg::ARRAY_IDLE;
      endcase
    end
  end

endmodule

/* rtl/matmul_regs.sv */
`timescale 1ns/100ps
`include "matmul_settings.svh"

module matmul_regs (
  input  logic clk_i,
  input  logic reset_i,
  input  logic reg_we_i, // one-cycle write strobe
  input  matmul_pkg::reg_addr_t reg_addr_i,
  input  matmul_pkg::word_t reg_wdata_i,
  input  logic busy_i, // array running
  output logic start_o, // one cycle, job valid with it
  output matmul_pkg::matmul_job_t job_o
);

  localparam int IDX_W = $clog2(`MATMUL_DIM);
  localparam int START_BIT = 8; // control word start bit

  logic write_ok; // accepted write
  logic [IDX_W-1:0] word_idx; // row or column select

  // start cycle counts as busy so the sampled job cannot move
  assign write_ok = reg_we_i && !busy_i && !start_o;
  assign word_idx = reg_addr_i[IDX_W-1:0];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      start_o <= 1'b0;
      job_o <= '0;
    end
    else
    begin
      start_o <= 1'b0; // strobe only
      if (write_ok)
      begin
        if (reg_addr_i < `MATMUL_DIM)
        begin
          job_o.a_rows[word_idx] <= reg_wdata_i; // A row
        end
        else if (reg_addr_i < 2 * `MATMUL_DIM)
        begin
          job_o.b_cols[word_idx] <= reg_wdata_i; // B column
        end
        else if (reg_addr_i == `MATMUL_CTRL_ADDR)
        begin
          // dims stored as size minus one
          job_o.dim_n <= reg_wdata_i[1:0];
          job_o.dim_k <= reg_wdata_i[3:2];
          job_o.dim_m <= reg_wdata_i[5:4];
          start_o <= reg_wdata_i[START_BIT];
        end
        // unmapped addresses fall through
      end
    end
  end

endmodule

/* rtl/matmul_top.sv */
`timescale 1ns/100ps
`include "matmul_settings.svh"

module matmul_top (
  input  logic clk_i,
  input  logic reset_i,
  input  logic reg_we_i, // host write strobe
  input  matmul_pkg::reg_addr_t reg_addr_i,
  input  matmul_pkg::word_t reg_wdata_i,
  output logic busy_o,
  output logic done_o, // one cycle, result valid
  output matmul_pkg::matmul_result_t result_o
);

  logic start; // regs to array
  matmul_pkg::matmul_job_t job;

  // register block next to the array it steers
  matmul_regs i_matmul_regs (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .busy_i      (busy_o), // blocks writes during a run
    .start_o     (start),
    .job_o       (job)
  );

  matmul_array i_matmul_array (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .start_i  (start),
    .job_i    (job),
    .busy_o   (busy_o),
    .done_o   (done_o),
    .result_o (result_o)
  );

endmodule

/* verification/matmul_props.sv */
`timescale 1ns/100ps
`include "matmul_settings.svh"

module matmul_props (
  input logic clk_i,
  input logic reset_i,
  input logic start_i, // regs to array strobe
  input logic busy_i,
  input logic done_i
);

  int failures = 0; // failed assertions so far

  // strobe never stretches
  done_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    done_i |=> !done_i)
    else
    begin
      $error("done strobe held for two cycles");
      failures++;
    end

  // busy from the cycle after start up to and including done
  busy_during_run: assert property (@(posedge clk_i) disable iff (reset_i)
    start_i |=> busy_i [*`MATMUL_LATENCY])
    else
    begin
      $error("busy dropped during a run");
      failures++;
    end

  done_after_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    done_i |-> $past(busy_i))
    else
    begin
      $error("done without busy in the cycle before");
      failures++;
    end

  quiet_after_reset: assert property (@(posedge clk_i)
    reset_i |=> (!done_i && !busy_i))
    else
    begin
      $error("done or busy high right after reset");
      failures++;
    end

endmodule

bind matmul_top matmul_props i_matmul_props (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .start_i (start),
  .busy_i  (busy_o),
  .done_i  (done_o)
);

/* verification/matmul_tb.sv */
`timescale 1ns/100ps
`include "matmul_settings.svh"

module matmul_tb;

  localparam int NUM_JOBS = 200;
  localparam int CYCLES_PER_JOB = 40; // worst case job is about 42, average far less
  localparam int TIMEOUT_CYCLES = NUM_JOBS * CYCLES_PER_JOB * 5 / 4; // 10000
  localparam int DONE_WAIT = 4 * (`MATMUL_LATENCY + 1); // per job done window

  logic clk_i;
  logic reset_i;
  logic reg_we_i;
  matmul_pkg::reg_addr_t reg_addr_i;
  matmul_pkg::word_t reg_wdata_i;
  logic busy_o;
  logic done_o;
  matmul_pkg::matmul_result_t result_o;

  logic [31:0] lfsr_state; // galois lfsr, one step per bit
  matmul_pkg::word_t a_sh [`MATMUL_DIM]; // shadow of A rows
  matmul_pkg::word_t b_sh [`MATMUL_DIM]; // shadow of B columns
  int word_errors;
  int flag_errors;
  int latency_errors;
  int other_errors;
  int assert_errors;
  int cycle_count;

  matmul_top i_matmul_top (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .reg_we_i    (reg_we_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .result_o    (result_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i; // 10 ns period
  end

  // x^32+x^22+x^2+x+1, right shifting form
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw(input int nbits, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]}; // one bit per step
    end
  endtask

  // full product in wide ints, then wrap and pack row-major, stride m
  function automatic matmul_pkg::matmul_result_t model_product(input int n, input int k,
                                                               input int m);
    matmul_pkg::matmul_result_t res;
    int sum;
    int av;
    int bv;
    logic [15:0] low;
    logic ovf;
    res = '0;
    for (int r = 0; r < n; r++)
    begin
      for (int c = 0; c < m; c++)
      begin
        sum = 0;
        ovf = 1'b0;
        for (int kk = 0; kk < k; kk++)
        begin
          av = int'($signed(a_sh[r][kk*8 +: 8]));
          bv = int'($signed(b_sh[c][kk*8 +: 8]));
          sum = sum + av * bv;
          if ((sum > 32767) || (sum < -32768))
            ovf = 1'b1; // any partial sum out of range
        end
        low = sum[15:0]; // wraps
        res.data[r*m+c] = {{16{low[15]}}, low};
        res.flags[r*m+c] = ovf;
      end
    end
    return res;
  endfunction

  task automatic check_word(input matmul_pkg::word_t got, input matmul_pkg::word_t exp,
                            input int job, input int idx);
    if (got !== exp)
    begin
      word_errors++;
      $display("error at %0t: job %0d word %0d got %h expected %h", $time, job, idx, got, exp);
    end
  endtask

  task automatic check_flags(input matmul_pkg::flags_t got, input matmul_pkg::flags_t exp,
                             input int job);
    if (got !== exp)
    begin
      flag_errors++;
      $display("error at %0t: job %0d flags got %h expected %h", $time, job, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int job);
    if (got != `MATMUL_LATENCY + 1)
    begin
      latency_errors++;
      $display("error at %0t: job %0d done after %0d cycles expected %0d", $time, job, got,
               `MATMUL_LATENCY + 1);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1; // drive and sample just after the edge
  endtask

  task automatic write_reg(input matmul_pkg::reg_addr_t addr, input matmul_pkg::word_t data);
    reg_we_i = 1'b1;
    reg_addr_i = addr;
    reg_wdata_i = data;
    next_cycle();
    reg_we_i = 1'b0;
  endtask

  task automatic run_job(input int job);
    logic [31:0] r;
    logic [31:0] sel;
    logic [1:0] dn;
    logic [1:0] dk;
    logic [1:0] dm;
    logic [7:0] e;
    matmul_pkg::word_t w;
    matmul_pkg::matmul_result_t exp;
    int kind;
    int drops;
    int cycles;
    logic seen;
    draw(2, r);
    kind = int'(r[1:0]); // 0 full size, 2 extreme heavy
    draw(6, r);
    dn = (kind == 0) ? 2'd3 : r[1:0];
    dk = (kind == 0) ? 2'd3 : r[3:2];
    dm = (kind == 0) ? 2'd3 : r[5:4];
    for (int i = 0; i < 2 * `MATMUL_DIM; i++)
    begin
      draw(2, r);
      if (r[1:0] != 2'd0) // else keep old register value
      begin
        for (int b = 0; b < 4; b++)
        begin
          draw(3, sel);
          if ((sel[2:0] == 3'd7) || ((kind == 2) && (sel[1:0] != 2'd0)))
          begin
            draw(1, r);
            e = r[0] ? 8'h7f : 8'h80; // push toward overflow
          end
          else
          begin
            draw(8, r);
            e = r[7:0];
          end
          w[b*8 +: 8] = e;
        end
        write_reg(matmul_pkg::reg_addr_t'(i), w);
        if (i < `MATMUL_DIM)
          a_sh[i] = w;
        else
          b_sh[i - `MATMUL_DIM] = w;
      end
      draw(2, r);
      if (r[1:0] == 2'd3)
        repeat (2) next_cycle(); // idle gap
    end
    draw(2, r);
    if (r[1:0] == 2'd0)
    begin
      draw(3, sel);
      draw(32, r);
      write_reg(matmul_pkg::reg_addr_t'(9 + sel % 7), r); // unmapped, no effect
    end
    exp = model_product(int'(dn) + 1, int'(dk) + 1, int'(dm) + 1);
    draw(2, r);
    drops = int'(r[1:0]); // writes thrown at the busy array
    reg_we_i = 1'b1;
    reg_addr_i = matmul_pkg::reg_addr_t'(`MATMUL_CTRL_ADDR);
    reg_wdata_i = matmul_pkg::word_t'({1'b1, 2'b00, dm, dk, dn});
    cycles = 0;
    seen = 1'b0;
    while (!seen && (cycles < DONE_WAIT))
    begin
      next_cycle();
      cycles++;
      reg_we_i = 1'b0;
      if (done_o)
        seen = 1'b1;
      else if ((drops > 0) && busy_o)
      begin
        draw(4, sel);
        draw(32, r);
        reg_we_i = 1'b1;
        reg_addr_i = matmul_pkg::reg_addr_t'(sel % 9); // any mapped register
        reg_wdata_i = r; // start bit may be set too
        drops--;
      end
    end
    if (!seen)
    begin
      other_errors++;
      $display("done_o never arrived for job %0d within %0d cycles", job, DONE_WAIT);
    end
    else
    begin
      check_latency(cycles, job);
      for (int i = 0; i < `MATMUL_DIM * `MATMUL_DIM; i++)
        check_word(result_o.data[i], exp.data[i], job, i);
      check_flags(result_o.flags, exp.flags, job);
      next_cycle(); // busy falls right after done
      if (busy_o)
      begin
        other_errors++;
        $display("error at %0t: job %0d busy_o still high the cycle after done", $time, job);
      end
    end
    cycles = 0;
    while (busy_o && (cycles < DONE_WAIT))
    begin
      next_cycle();
      cycles++;
    end
  endtask

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    lfsr_state = 32'h8a2b;
    word_errors = 0;
    flag_errors = 0;
    latency_errors = 0;
    other_errors = 0;
    assert_errors = 0;
    reset_i = 1'b1;
    reg_we_i = 1'b0;
    reg_addr_i = '0;
    reg_wdata_i = '0;
    for (int i = 0; i < `MATMUL_DIM; i++)
    begin
      a_sh[i] = '0; // registers reset to zero
      b_sh[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    for (int i = 0; i < `MATMUL_DIM * `MATMUL_DIM; i++)
      check_word(result_o.data[i], '0, -1, i); // result cleared by reset
    check_flags(result_o.flags, '0, -1);
    for (int j = 0; j < NUM_JOBS; j++)
      run_job(j);
    assert_errors = i_matmul_top.i_matmul_props.failures;
    $display("errors: word %0d, flags %0d, latency %0d, other %0d, assertions %0d", word_errors,
             flag_errors, latency_errors, other_errors, assert_errors);
    if ((word_errors + flag_errors + latency_errors + other_errors + assert_errors) == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* build.f */
+incdir+include
rtl/matmul_pkg.sv
rtl/matmul_pe.sv
rtl/matmul_array.sv
rtl/matmul_regs.sv
rtl/matmul_top.sv
verification/matmul_props.sv
verification/matmul_tb.sv

/* Bender.yml */
package:
  name: matmul

export_include_dirs:
  - include

sources:
  - rtl/matmul_pkg.sv
  - rtl/matmul_pe.sv
  - rtl/matmul_array.sv
  - rtl/matmul_regs.sv
  - rtl/matmul_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/matmul_props.sv
      - verification/matmul_tb.sv
